/* src/bridge_pkg.sv */
package bridge_pkg;

    // frame start byte
    localparam logic [7:0] frame_header = 8'hAA;

    // command codes
    localparam logic [7:0] cmd_pwm        = 8'h01;
    localparam logic [7:0] cmd_uart_tx    = 8'h02;
    localparam logic [7:0] cmd_led_toggle = 8'h03;

    // parser result handed to the command processor
    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] len;
    } frame_info_t;

    // shared command bus, driven by the processor, read by every handler
    typedef struct packed {
        logic [7:0]  cmd_type;
        logic [15:0] length;
        logic [7:0]  data;
        logic [15:0] index;
        // one-cycle pulse before any data
        logic        start;
        // one pulse per payload byte
        logic        data_valid;
        // one cycle after the last byte
        logic        done;
    } cmd_bus_t;

endpackage

/* src/protocol_parser.sv */
module protocol_parser #(
    parameter int MAX_PAYLOAD_LEN = 256
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [7:0]                         data_in,
    input  logic                               data_valid,
    input  logic [$clog2(MAX_PAYLOAD_LEN)-1:0] payload_read_addr,
    output logic [7:0]                         payload_read_data,
    output logic                               parse_done,
    output logic                               parse_error,
    output bridge_pkg::frame_info_t            frame
);
    import bridge_pkg::*;

    localparam int ADDR_W = $clog2(MAX_PAYLOAD_LEN);

    typedef enum logic [2:0] {
        ST_HEADER,
        ST_CMD,
        ST_LEN_HI,
        ST_LEN_LO,
        ST_PAYLOAD,
        ST_CHECKSUM
    } state_t;

    state_t      state;
    logic [7:0]  csum;
    logic [15:0] byte_cnt;
    logic [15:0] len_full;
    logic [7:0]  payload_mem [MAX_PAYLOAD_LEN];

    // length as seen while the low byte is on the input
    assign len_full = {frame.len[15:8], data_in};

    // payload buffer with a registered read port
    always_ff @(posedge clk) begin
        if (data_valid && state == ST_PAYLOAD) begin
            payload_mem[byte_cnt[ADDR_W-1:0]] <= data_in;
        end
        payload_read_data <= payload_mem[payload_read_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_HEADER;
            csum        <= '0;
            byte_cnt    <= '0;
            frame       <= '0;
            parse_done  <= 1'b0;
            parse_error <= 1'b0;
        end else begin
            parse_done  <= 1'b0;
            parse_error <= 1'b0;
            if (data_valid) begin
                case (state)
                    ST_HEADER: begin
                        // anything but the header byte is dropped here
                        if (data_in == frame_header) begin
                            state <= ST_CMD;
                        end
                    end
                    ST_CMD: begin
                        frame.cmd <= data_in;
                        csum      <= data_in;
                        state     <= ST_LEN_HI;
                    end
                    ST_LEN_HI: begin
                        frame.len[15:8] <= data_in;
                        csum            <= csum ^ data_in;
                        state           <= ST_LEN_LO;
                    end
                    ST_LEN_LO: begin
                        frame.len[7:0] <= data_in;
                        csum           <= csum ^ data_in;
                        byte_cnt       <= '0;
                        if (len_full > 16'(MAX_PAYLOAD_LEN)) begin
                            // too long for the buffer, resync on next header
                            parse_error <= 1'b1;
                            state       <= ST_HEADER;
                        end else if (len_full == 16'd0) begin
                            state <= ST_CHECKSUM;
                        end else begin
                            state <= ST_PAYLOAD;
                        end
                    end
                    ST_PAYLOAD: begin
                        csum     <= csum ^ data_in;
                        byte_cnt <= byte_cnt + 16'd1;
                        if (byte_cnt == frame.len - 16'd1) begin
                            state <= ST_CHECKSUM;
                        end
                    end
                    ST_CHECKSUM: begin
                        if (csum == data_in) begin
                            parse_done <= 1'b1;
                        end else begin
                            parse_error <= 1'b1;
                        end
                        state <= ST_HEADER;
                    end
                    default: begin
                        state <= ST_HEADER;
                    end
                endcase
            end
        end
    end

    a_done_error_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(parse_done && parse_error)
    );

endmodule

/* src/command_processor.sv */
module command_processor #(
    parameter int PAYLOAD_ADDR_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          parse_done,
    input  bridge_pkg::frame_info_t       frame,
    input  logic [7:0]                    payload_read_data,
    input  logic                          cmd_ready,
    output logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_addr,
    output bridge_pkg::cmd_bus_t          cmd_bus,
    output logic                          led_out
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FINISH
    } state_t;

    state_t      state;
    logic [15:0] rd_idx;
    // read data for rd_idx is on payload_read_data
    logic        in_flight;
    logic        last_byte;

    // address stays put while the handlers hold off
    assign payload_read_addr = rd_idx[PAYLOAD_ADDR_WIDTH-1:0];
    assign last_byte         = (rd_idx == cmd_bus.length - 16'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            rd_idx    <= '0;
            in_flight <= 1'b0;
            cmd_bus   <= '0;
            led_out   <= 1'b0;
        end else begin
            cmd_bus.start      <= 1'b0;
            cmd_bus.data_valid <= 1'b0;
            cmd_bus.done       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (parse_done) begin
                        cmd_bus.cmd_type <= frame.cmd;
                        cmd_bus.length   <= frame.len;
                        cmd_bus.start    <= 1'b1;
                        rd_idx           <= '0;
                        in_flight        <= 1'b0;
                        // empty payload goes straight to done
                        state <= (frame.len == 16'd0) ? ST_FINISH : ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (!in_flight) begin
                        // one cycle of read latency
                        in_flight <= 1'b1;
                    end else if (cmd_ready) begin
                        cmd_bus.data       <= payload_read_data;
                        cmd_bus.index      <= rd_idx;
                        cmd_bus.data_valid <= 1'b1;
                        in_flight          <= 1'b0;
                        rd_idx             <= rd_idx + 16'd1;
                        if (last_byte) begin
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_FINISH: begin
                    cmd_bus.done <= 1'b1;
                    if (cmd_bus.cmd_type == cmd_led_toggle) begin
                        led_out <= ~led_out;
                    end
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // a handler may drop ready only after it has taken a byte
    a_valid_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n) cmd_bus.data_valid |-> cmd_ready
    );

endmodule

/* src/pwm_handler.sv */
module pwm_handler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bridge_pkg::cmd_bus_t cmd_bus,
    output logic                 pwm_ready,
    output logic [7:0]           pwm_pins
);
    import bridge_pkg::*;

    logic [7:0] duty [8];
    logic [7:0] pwm_cnt;
    logic [7:0] channel;
    logic       pwm_write;

    assign pwm_write = cmd_bus.data_valid && (cmd_bus.cmd_type == cmd_pwm);

    // duty writes finish in one cycle, never stall the bus
    assign pwm_ready = 1'b1;

    // period of 256 cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 8'd1;
        end
    end

    // even index picks the channel, odd index carries its duty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            channel <= '0;
            for (int i = 0; i < 8; i++) begin
                duty[i] <= '0;
            end
        end else if (pwm_write) begin
            if (!cmd_bus.index[0]) begin
                channel <= cmd_bus.data;
            end else if (channel < 8'd8) begin
                duty[channel[2:0]] <= cmd_bus.data;
            end
        end
    end

    for (genvar i = 0; i < 8; i++) begin : g_pin
        assign pwm_pins[i] = (pwm_cnt < duty[i]);
    end

endmodule

/* src/uart_handler.sv */
module uart_handler #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bridge_pkg::cmd_bus_t cmd_bus,
    output logic                 uart_ready,
    output logic                 ext_uart_tx
);
    import bridge_pkg::*;

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);

    logic              busy;
    logic              tx_accept;
    logic              bit_end;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    // stop bit above the data byte, shifted out lsb first
    logic [8:0]        tx_shift;

    assign tx_accept  = cmd_bus.data_valid && (cmd_bus.cmd_type == cmd_uart_tx) && !busy;
    assign bit_end    = (baud_cnt == BAUD_LAST);
    assign uart_ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            baud_cnt    <= '0;
            bit_cnt     <= '0;
            tx_shift    <= '1;
            ext_uart_tx <= 1'b1;
        end else if (tx_accept) begin
            // start bit goes out right away
            busy        <= 1'b1;
            baud_cnt    <= '0;
            bit_cnt     <= '0;
            tx_shift    <= {1'b1, cmd_bus.data};
            ext_uart_tx <= 1'b0;
        end else if (busy) begin
            if (bit_end) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // stop bit done, line stays idle high
                    busy <= 1'b0;
                end else begin
                    bit_cnt     <= bit_cnt + 4'd1;
                    ext_uart_tx <= tx_shift[0];
                    tx_shift    <= {1'b1, tx_shift[8:1]};
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // processor must wait for ready before the next byte
    a_no_byte_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmd_bus.data_valid && cmd_bus.cmd_type == cmd_uart_tx) |-> uart_ready
    );

endmodule

/* src/cmd_bridge.sv */
module cmd_bridge #(
    parameter int MAX_PAYLOAD_LEN = 256,
    parameter int CLKS_PER_BIT    = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] data_in,
    input  logic       data_valid,
    output logic       led_out,
    output logic [7:0] pwm_pins,
    output logic       ext_uart_tx
);
    import bridge_pkg::*;

    localparam int PAYLOAD_ADDR_WIDTH = $clog2(MAX_PAYLOAD_LEN);

    logic                          parse_done;
    logic                          parse_error;
    frame_info_t                   frame;
    logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_addr;
    logic [7:0]                    payload_read_data;
    cmd_bus_t                      cmd_bus;
    logic                          pwm_ready;
    logic                          uart_ready;
    logic                          cmd_ready;

    // bus moves only when every handler can take a byte
    assign cmd_ready = pwm_ready & uart_ready;

    protocol_parser #(
        .MAX_PAYLOAD_LEN(MAX_PAYLOAD_LEN)
    ) u_parser (
        .clk              (clk),
        .rst_n            (rst_n),
        .data_in          (data_in),
        .data_valid       (data_valid),
        .payload_read_addr(payload_read_addr),
        .payload_read_data(payload_read_data),
        .parse_done       (parse_done),
        .parse_error      (parse_error),
        .frame            (frame)
    );

    command_processor #(
        .PAYLOAD_ADDR_WIDTH(PAYLOAD_ADDR_WIDTH)
    ) u_command_processor (
        .clk              (clk),
        .rst_n            (rst_n),
        .parse_done       (parse_done),
        .frame            (frame),
        .payload_read_data(payload_read_data),
        .cmd_ready        (cmd_ready),
        .payload_read_addr(payload_read_addr),
        .cmd_bus          (cmd_bus),
        .led_out          (led_out)
    );

    pwm_handler u_pwm_handler (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_bus  (cmd_bus),
        .pwm_ready(pwm_ready),
        .pwm_pins (pwm_pins)
    );

    uart_handler #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_handler (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_bus    (cmd_bus),
        .uart_ready (uart_ready),
        .ext_uart_tx(ext_uart_tx)
    );

endmodule

/* testbench/tb_clock.sv */
module tb_clock #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/tb_cmd_bridge.sv */
module tb_cmd_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    import bridge_pkg::*;

    localparam int MAX_PAYLOAD_LEN = 16;
    localparam int CLKS_PER_BIT    = 4;
    localparam int NUM_FRAMES      = 13;
    localparam int RESULT_WAIT     = (MAX_PAYLOAD_LEN + 2) * 12 * CLKS_PER_BIT + 50;

    // one row of the frame table
    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] len;
        // first channel written by a pwm frame
        logic [7:0]  chan_base;
        logic        corrupt;
        // non-header bytes sent before the frame
        logic [3:0]  garbage;
        logic        accept;
    } frame_spec_t;

    localparam frame_spec_t FRAME_TABLE [NUM_FRAMES] = '{
        '{cmd_pwm,        16'd4,  8'd0, 1'b0, 4'd0, 1'b1},
        '{cmd_uart_tx,    16'd3,  8'd0, 1'b0, 4'd0, 1'b1},
        '{cmd_led_toggle, 16'd0,  8'd0, 1'b0, 4'd0, 1'b1},
        // channel 8 must be ignored
        '{cmd_pwm,        16'd6,  8'd6, 1'b0, 4'd0, 1'b1},
        '{cmd_pwm,        16'd4,  8'd2, 1'b1, 4'd0, 1'b0},
        '{cmd_uart_tx,    16'd2,  8'd0, 1'b1, 4'd0, 1'b0},
        '{cmd_led_toggle, 16'd2,  8'd0, 1'b0, 4'd3, 1'b1},
        '{cmd_led_toggle, 16'd0,  8'd0, 1'b1, 4'd0, 1'b0},
        // longer than the payload buffer
        '{cmd_uart_tx,    16'd17, 8'd0, 1'b0, 4'd0, 1'b0},
        '{cmd_pwm,        16'd8,  8'd2, 1'b0, 4'd2, 1'b1},
        '{cmd_uart_tx,    16'd5,  8'd0, 1'b0, 4'd1, 1'b1},
        // unknown command that no handler takes
        '{8'h07,          16'd3,  8'd0, 1'b0, 4'd0, 1'b1},
        '{cmd_led_toggle, 16'd1,  8'd0, 1'b0, 4'd0, 1'b1}
    };

    logic       clk;
    logic       rst_n;
    logic [7:0] data_in;
    logic       data_valid;
    logic       led_out;
    logic [7:0] pwm_pins;
    logic       ext_uart_tx;

    logic [31:0] lfsr_state = 32'h0074_9b46;
    logic [7:0]  tx_bytes [$];
    logic [7:0]  payload [$];
    logic [7:0]  rx_q [$];
    logic [7:0]  exp_rx [$];
    logic [7:0]  exp_duty [8];
    logic        exp_led;
    int          pwm_high [8];

    tb_clock #(
        .RESET_CYCLES(5)
    ) u_clock (
        .clk  (clk),
        .rst_n(rst_n)
    );

    cmd_bridge #(
        .MAX_PAYLOAD_LEN(MAX_PAYLOAD_LEN),
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .data_valid (data_valid),
        .led_out    (led_out),
        .pwm_pins   (pwm_pins),
        .ext_uart_tx(ext_uart_tx)
    );

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            end_with_failure($sformatf("error: time %0t, %s is %0h, expected %0h",
                                       $time, name, actual, expected));
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        for (int i = 0; i < 8; i++) begin
            value[i] = lfsr_bit();
        end
        return value;
    endfunction

    function automatic int frame_length(input frame_spec_t spec);
        if (spec.len > 16'(MAX_PAYLOAD_LEN)) begin
            return int'(spec.garbage) + 4;
        end
        return int'(spec.garbage) + 5 + int'(spec.len);
    endfunction

    function automatic int watchdog_cycles();
        int bytes;
        bytes = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            bytes += frame_length(FRAME_TABLE[f]);
        end
        return 2 * (bytes * 10 * CLKS_PER_BIT + NUM_FRAMES * 600);
    endfunction

    // fills tx_bytes and payload for one table row
    task automatic build_frame(input frame_spec_t spec);
        logic [7:0] b;
        logic [7:0] csum;
        tx_bytes.delete();
        payload.delete();
        for (int i = 0; i < int'(spec.garbage); i++) begin
            b = random_byte();
            if (b == frame_header) begin
                b = 8'h00;
            end
            tx_bytes.push_back(b);
        end
        tx_bytes.push_back(frame_header);
        tx_bytes.push_back(spec.cmd);
        tx_bytes.push_back(spec.len[15:8]);
        tx_bytes.push_back(spec.len[7:0]);
        csum = spec.cmd ^ spec.len[15:8] ^ spec.len[7:0];
        if (spec.len <= 16'(MAX_PAYLOAD_LEN)) begin
            for (int i = 0; i < int'(spec.len); i++) begin
                if (spec.cmd == cmd_pwm && i % 2 == 0) begin
                    b = 8'(int'(spec.chan_base) + i / 2);
                end else begin
                    b = random_byte();
                end
                payload.push_back(b);
                tx_bytes.push_back(b);
                csum = csum ^ b;
            end
            tx_bytes.push_back(spec.corrupt ? ~csum : csum);
        end
    endtask

    task automatic send_bytes();
        foreach (tx_bytes[i]) begin
            @(posedge clk);
            data_in    <= tx_bytes[i];
            data_valid <= 1'b1;
        end
        @(posedge clk);
        data_valid <= 1'b0;
    endtask

    // good frames end with done on the bus and bad ones with a parser error
    task automatic wait_for_result(input logic accept);
        int  cycles;
        bit  finished;
        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (accept && u_dut.parse_error) begin
                end_with_failure("a good frame was rejected by the parser");
            end
            if (!accept && u_dut.parse_done) begin
                end_with_failure("a bad frame was accepted by the parser");
            end
            finished = accept ? u_dut.cmd_bus.done : u_dut.parse_error;
            cycles++;
            if (!finished && cycles > RESULT_WAIT) begin
                end_with_failure("no done or parse error after the frame was sent");
            end
        end
    endtask

    task automatic apply_expected(input frame_spec_t spec);
        int ch;
        if (spec.cmd == cmd_pwm) begin
            for (int j = 0; j < int'(spec.len) / 2; j++) begin
                ch = int'(spec.chan_base) + j;
                if (ch < 8) begin
                    exp_duty[ch] = payload[2 * j + 1];
                end
            end
        end else if (spec.cmd == cmd_uart_tx) begin
            foreach (payload[i]) begin
                exp_rx.push_back(payload[i]);
            end
        end else if (spec.cmd == cmd_led_toggle) begin
            exp_led = ~exp_led;
        end
    endtask

    task automatic wait_for_uart_bytes();
        int cycles;
        cycles = 0;
        while (rx_q.size() < exp_rx.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESULT_WAIT) begin
                end_with_failure("expected bytes never appeared on ext_uart_tx");
            end
        end
    endtask

    task automatic check_outputs();
        for (int ch = 0; ch < 8; ch++) begin
            pwm_high[ch] = 0;
        end
        // one full counter period
        repeat (256) begin
            @(negedge clk);
            for (int ch = 0; ch < 8; ch++) begin
                if (pwm_pins[ch]) begin
                    pwm_high[ch]++;
                end
            end
        end
        for (int ch = 0; ch < 8; ch++) begin
            check_value($sformatf("pwm_pins[%0d] high cycles", ch), 32'(pwm_high[ch]),
                        32'(exp_duty[ch]));
        end
        check_value("led_out", 32'(led_out), 32'(exp_led));
        check_value("uart byte count", 32'(rx_q.size()), 32'(exp_rx.size()));
        foreach (rx_q[i]) begin
            check_value($sformatf("uart byte %0d", i), 32'(rx_q[i]), 32'(exp_rx[i]));
        end
    endtask

    // 8N1 decoder sampling near the middle of each bit
    initial begin : uart_receiver
        logic [7:0] rx_byte;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (ext_uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                if (ext_uart_tx !== 1'b0) begin
                    end_with_failure("start bit on ext_uart_tx was too short");
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx_byte[b] = ext_uart_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (ext_uart_tx !== 1'b1) begin
                    end_with_failure("stop bit on ext_uart_tx was missing");
                end
                rx_q.push_back(rx_byte);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        end_with_failure($sformatf("timeout, run did not end within %0d cycles", limit));
    end

    initial begin : stimulus
        data_in    = 8'h00;
        data_valid = 1'b0;
        exp_led    = 1'b0;
        for (int ch = 0; ch < 8; ch++) begin
            exp_duty[ch] = 8'h00;
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("led_out", 32'(led_out), 32'd0);
        check_value("pwm_pins", 32'(pwm_pins), 32'd0);
        check_value("ext_uart_tx", 32'(ext_uart_tx), 32'd1);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            build_frame(FRAME_TABLE[f]);
            send_bytes();
            wait_for_result(FRAME_TABLE[f].accept);
            if (FRAME_TABLE[f].accept) begin
                apply_expected(FRAME_TABLE[f]);
            end
            wait_for_uart_bytes();
            check_outputs();
        end

        // nothing late on the serial line
        repeat (20 * CLKS_PER_BIT) @(negedge clk);
        check_value("uart byte count", 32'(rx_q.size()), 32'(exp_rx.size()));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* compile.f */
src/bridge_pkg.sv
src/protocol_parser.sv
src/command_processor.sv
src/pwm_handler.sv
src/uart_handler.sv
src/cmd_bridge.sv
testbench/tb_clock.sv
testbench/tb_cmd_bridge.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_cmd_bridge \
    -o sim_tb_cmd_bridge || exit 1
sim_out=$(./obj_dir/sim_tb_cmd_bridge)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "STATUS: PASS" && exit 0 || exit 1
